// File: exec_core.f
design/exec_pkg.sv
design/reg_file.sv
design/operand_bypass.sv
design/alu.sv
design/mul_unit.sv
design/div_unit.sv
design/exec_core.sv
dv/tb_exec_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_exec_core -Mdir obj_dir -f exec_core.f

output=$(./obj_dir/Vtb_exec_core)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'Finished with no errors'; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: dv/exec_input.txt
# op rd rs1 rs2 use_imm in decimal, then imm and expected retire value in hex
# A line starting with = opens a named test group
= reset_reads
0 1 0 0 1 12345678 12345678
3 2 5 0 1 0000ff00 0000ff00
0 3 6 7 0 00000000 00000000
4 4 8 0 1 80000001 80000001
= alu_forwarding
0 5 0 0 1 00000010 00000010
1 6 5 1 0 00000000 edcba998
2 7 6 2 0 00000000 0000a900
3 8 7 5 0 00000000 0000a910
4 9 8 6 0 00000000 edcb0088
5 10 9 0 1 00000004 dcb00880
6 11 10 5 0 00000000 0000dcb0
7 12 10 0 1 00000008 ffdcb008
8 13 12 11 0 00000000 00000001
9 14 12 11 0 00000000 00000000
5 15 13 0 1 00000024 00000010
9 17 15 0 1 ffffffff 00000001
= mul
0 20 0 0 1 ffffffff ffffffff
0 21 0 0 1 00010003 00010003
10 22 20 21 0 00000000 fffefffd
11 23 20 21 0 00000000 00010002
0 24 23 0 1 00000001 00010003
11 27 20 20 0 00000000 fffffffe
10 28 27 20 0 00000000 00000002
= div
0 30 0 0 1 000003e8 000003e8
12 31 30 0 1 00000007 0000008e
13 1 30 0 1 00000007 00000006
12 2 20 21 0 00000000 0000fffd
13 3 20 21 0 00000000 00000008
12 4 30 0 0 00000000 ffffffff
13 5 30 0 0 00000000 000003e8
0 6 4 5 0 00000000 000003e7
= x0_write
0 0 30 0 1 00000005 000003ed
3 9 0 0 0 00000000 00000000
0 10 0 30 0 00000000 000003e8

// File: dv/tb_exec_core.sv
`default_nettype none

module tb_exec_core import exec_pkg::*; ();

    localparam int XLEN       = 32;
    localparam int MAX_INSTR  = 64;
    localparam int WAIT_LIMIT = 200;

    logic                  clk;
    logic                  resetn;
    logic                  i_valid;
    logic                  o_ready;
    exec_op_e              i_op;
    logic [REG_ADDR_W-1:0] i_rd;
    logic [REG_ADDR_W-1:0] i_rs1;
    logic [REG_ADDR_W-1:0] i_rs2;
    logic                  i_use_imm;
    logic [XLEN-1:0]       i_imm;
    logic                  o_wb_valid;
    logic [REG_ADDR_W-1:0] o_wb_rd;
    logic [XLEN-1:0]       o_wb_data;

    // One entry per instruction line of the input file
    logic [3:0]            vec_op      [MAX_INSTR];
    logic [REG_ADDR_W-1:0] vec_rd      [MAX_INSTR];
    logic [REG_ADDR_W-1:0] vec_rs1     [MAX_INSTR];
    logic [REG_ADDR_W-1:0] vec_rs2     [MAX_INSTR];
    logic                  vec_use_imm [MAX_INSTR];
    logic [XLEN-1:0]       vec_imm     [MAX_INSTR];
    logic [XLEN-1:0]       vec_exp     [MAX_INSTR];
    int                    vec_group   [MAX_INSTR];
    string                 group_name   [$];
    int                    group_last   [$];
    int                    group_errors [$];

    int          n_instr      = 0;
    int          retired      = 0;
    int          errors       = 0;
    int          checks       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    bit          aborted      = 1'b0;
    logic [31:0] rng          = 32'h937c7003;

    exec_core #(.XLEN(XLEN)) i_exec_core (
        .clk        (clk),
        .resetn     (resetn),
        .i_valid    (i_valid),
        .o_ready    (o_ready),
        .i_op       (i_op),
        .i_rd       (i_rd),
        .i_rs1      (i_rs1),
        .i_rs2      (i_rs2),
        .i_use_imm  (i_use_imm),
        .i_imm      (i_imm),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_test(input string name, input int errs);
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %s: %s (%0d errors)", name, errs == 0 ? "passed" : "FAILED", errs);
    endtask

    task automatic load_vectors();
        int          fd;
        string       line;
        string       name;
        int          op;
        int          rd;
        int          rs1;
        int          rs2;
        int          use_imm;
        logic [31:0] imm;
        logic [31:0] exp_val;
        fd = $fopen("dv/exec_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open dv/exec_input.txt");
            aborted = 1'b1;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // Group marker lines name the test that follows
            if (line.len() > 0 && line[0] == "=") begin
                if ($sscanf(line, "= %s", name) == 1) begin
                    group_name.push_back(name);
                    group_last.push_back(-1);
                    group_errors.push_back(0);
                end
            end else if (line.len() > 0 && line[0] != "#" &&
                         $sscanf(line, "%d %d %d %d %d %h %h",
                                 op, rd, rs1, rs2, use_imm, imm, exp_val) == 7) begin
                if (n_instr >= MAX_INSTR || group_name.size() == 0) begin
                    $display("Instruction line outside a test group or beyond %0d lines",
                             MAX_INSTR);
                    aborted = 1'b1;
                end else begin
                    vec_op[n_instr]      = op[3:0];
                    vec_rd[n_instr]      = rd[REG_ADDR_W-1:0];
                    vec_rs1[n_instr]     = rs1[REG_ADDR_W-1:0];
                    vec_rs2[n_instr]     = rs2[REG_ADDR_W-1:0];
                    vec_use_imm[n_instr] = use_imm[0];
                    vec_imm[n_instr]     = imm;
                    vec_exp[n_instr]     = exp_val;
                    vec_group[n_instr]   = group_name.size() - 1;
                    group_last[group_name.size() - 1] = n_instr;
                    n_instr++;
                end
            end
        end
        $fclose(fd);
        if (n_instr == 0) begin
            $display("No instructions were loaded from dv/exec_input.txt");
            aborted = 1'b1;
        end
    endtask

    task automatic apply_reset();
        int errs;
        int waited;
        errs   = 0;
        waited = 0;
        repeat (10) begin
            @(negedge clk);
            checks++;
            if (o_wb_valid !== 1'b0) begin
                $display("CHECK FAILED at %0t: o_wb_valid high during reset", $time);
                errors++;
                errs++;
            end
        end
        @(posedge clk);
        #2;
        resetn = 1'b1;
        @(negedge clk);
        while (o_ready !== 1'b1 && !aborted) begin
            if (waited >= WAIT_LIMIT) begin
                $display("Timed out waiting for o_ready after reset");
                aborted = 1'b1;
                errs++;
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        report_test("reset_state", errs);
    endtask

    // Called at posedge+2, returns at posedge+2 after the handshake
    task automatic send_instr(input int idx);
        int gap;
        int waited;
        rng    = xorshift32(rng);
        gap    = int'(rng[1:0]);
        waited = 0;
        repeat (gap) begin
            @(posedge clk);
            #2;
        end
        i_valid   = 1'b1;
        i_op      = exec_op_e'(vec_op[idx]);
        i_rd      = vec_rd[idx];
        i_rs1     = vec_rs1[idx];
        i_rs2     = vec_rs2[idx];
        i_use_imm = vec_use_imm[idx];
        i_imm     = vec_imm[idx];
        @(negedge clk);
        while (o_ready !== 1'b1 && !aborted) begin
            if (waited >= WAIT_LIMIT) begin
                $display("Timed out waiting for o_ready on instruction %0d", idx);
                aborted = 1'b1;
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        @(posedge clk);
        #2;
        i_valid = 1'b0;
    endtask

    task automatic check_retire();
        int g;
        if (retired >= n_instr) begin
            $display("Unexpected extra retirement of x%0d at %0t", o_wb_rd, $time);
            errors++;
        end else begin
            g = vec_group[retired];
            checks++;
            if (o_wb_rd !== vec_rd[retired]) begin
                $display("CHECK FAILED at %0t: instruction %0d retired x%0d, expected x%0d",
                         $time, retired, o_wb_rd, vec_rd[retired]);
                errors++;
                group_errors[g] = group_errors[g] + 1;
            end
            checks++;
            if (o_wb_data !== vec_exp[retired]) begin
                $display("CHECK FAILED at %0t: instruction %0d data %h, expected %h",
                         $time, retired, o_wb_data, vec_exp[retired]);
                errors++;
                group_errors[g] = group_errors[g] + 1;
            end
            if (group_last[g] == retired) begin
                report_test(group_name[g], group_errors[g]);
            end
        end
        retired++;
    endtask

    task automatic drain();
        int waited;
        int errs;
        waited = 0;
        errs   = 0;
        while (retired < n_instr && !aborted) begin
            if (waited >= WAIT_LIMIT) begin
                $display("Timed out waiting for retirements, %0d of %0d seen", retired, n_instr);
                aborted = 1'b1;
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        // Idle cycles to catch stray retirements
        repeat (20) begin
            @(posedge clk);
        end
        checks++;
        if (retired != n_instr) begin
            $display("CHECK FAILED at %0t: %0d retirements, expected %0d",
                     $time, retired, n_instr);
            errors++;
            errs++;
        end
        report_test("retire_order", errs);
    endtask

    always @(negedge clk) begin
        if (resetn === 1'b1 && o_wb_valid === 1'b1) begin
            check_retire();
        end
    end

    initial begin
        resetn    = 1'b0;
        i_valid   = 1'b0;
        i_op      = OP_ADD;
        i_rd      = '0;
        i_rs1     = '0;
        i_rs2     = '0;
        i_use_imm = 1'b0;
        i_imm     = '0;
        load_vectors();
        apply_reset();
        if (!aborted) begin
            @(posedge clk);
            #2;
            for (int i = 0; i < n_instr && !aborted; i++) begin
                send_instr(i);
            end
            drain();
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && !aborted) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/exec_core.sv
`default_nettype none

module exec_core import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  i_valid,
    output logic                  o_ready,
    input  exec_op_e              i_op,
    input  logic [REG_ADDR_W-1:0] i_rd,
    input  logic [REG_ADDR_W-1:0] i_rs1,
    input  logic [REG_ADDR_W-1:0] i_rs2,
    input  logic                  i_use_imm,
    input  logic [XLEN-1:0]       i_imm,
    output logic                  o_wb_valid,
    output logic [REG_ADDR_W-1:0] o_wb_rd,
    output logic [XLEN-1:0]       o_wb_data
);

    logic                  accept;

    // Issue register
    logic                  issue_valid;
    exec_op_e              issue_op;
    logic [REG_ADDR_W-1:0] issue_rd;
    logic [REG_ADDR_W-1:0] issue_rs1;
    logic [REG_ADDR_W-1:0] issue_rs2;
    logic                  issue_use_imm;
    logic [XLEN-1:0]       issue_imm;
    logic                  issue_go;
    logic                  stall;
    logic [XLEN-1:0]       rf_rs1;
    logic [XLEN-1:0]       rf_rs2;
    logic [XLEN-1:0]       rs1_value;
    logic [XLEN-1:0]       rs2_value;
    logic [XLEN-1:0]       op_b;
    logic [XLEN-1:0]       alu_result;

    // EX1
    logic                  ex1_valid;
    logic                  ex1_go;
    exec_op_e              ex1_op;
    func_unit_e            ex1_unit;
    logic [REG_ADDR_W-1:0] ex1_rd;
    logic [XLEN-1:0]       ex1_data;
    logic [XLEN-1:0]       ex1_data2;

    // EX2
    logic                  ex2_valid;
    logic                  ex2_free;
    func_unit_e            ex2_unit;
    logic [REG_ADDR_W-1:0] ex2_rd;
    logic [XLEN-1:0]       ex2_alu_data;
    logic                  ex2_data_valid;
    logic [XLEN-1:0]       ex2_data;
    logic                  mul_done;
    logic [XLEN-1:0]       mul_result;
    logic                  div_done;
    logic [XLEN-1:0]       div_result;

    assign ex1_unit = unit_of(ex1_op);
    assign ex2_free = !ex2_valid || ex2_data_valid;
    assign ex1_go   = ex1_valid && ex2_free;
    assign issue_go = issue_valid && !stall && (!ex1_valid || ex1_go);
    assign o_ready  = !issue_valid || issue_go;
    assign accept   = i_valid && o_ready;
    assign op_b     = issue_use_imm ? issue_imm : rs2_value;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            issue_valid <= 1'b0;
            ex1_valid   <= 1'b0;
            ex2_valid   <= 1'b0;
        end else begin
            if (o_ready) begin
                issue_valid <= i_valid;
            end
            if (issue_go) begin
                ex1_valid <= 1'b1;
            end else if (ex1_go) begin
                ex1_valid <= 1'b0;
            end
            if (ex1_go) begin
                ex2_valid <= 1'b1;
            end else if (ex2_data_valid) begin
                ex2_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue_op      <= i_op;
            issue_rd      <= i_rd;
            issue_rs1     <= i_rs1;
            issue_rs2     <= i_rs2;
            issue_use_imm <= i_use_imm;
            issue_imm     <= i_imm;
        end
        if (issue_go) begin
            ex1_op    <= issue_op;
            ex1_rd    <= issue_rd;
            // MUL and DIV carry raw operands into EX2
            ex1_data  <= unit_of(issue_op) == FU_ALU ? alu_result : rs1_value;
            ex1_data2 <= op_b;
        end
        if (ex1_go) begin
            ex2_unit     <= ex1_unit;
            ex2_rd       <= ex1_rd;
            ex2_alu_data <= ex1_data;
        end
    end

    always_comb begin
        ex2_data_valid = 1'b0;
        ex2_data       = ex2_alu_data;
        case (ex2_unit)
            FU_ALU: begin
                ex2_data_valid = ex2_valid;
            end
            FU_MUL: begin
                ex2_data_valid = ex2_valid && mul_done;
                ex2_data       = mul_result;
            end
            FU_DIV: begin
                ex2_data_valid = ex2_valid && div_done;
                ex2_data       = div_result;
            end
            default: begin
            end
        endcase
    end

    assign o_wb_valid = ex2_data_valid;
    assign o_wb_rd    = ex2_rd;
    assign o_wb_data  = ex2_data;

    reg_file #(.XLEN(XLEN)) u_reg_file (
        .clk       (clk),
        .resetn    (resetn),
        .i_ra_sel  (i_rs1),
        .i_rb_sel  (i_rs2),
        .i_ra_load (accept),
        .o_ra_data (rf_rs1),
        .o_rb_data (rf_rs2),
        .i_w_en    (ex2_data_valid),
        .i_w_sel   (ex2_rd),
        .i_w_data  (ex2_data)
    );

    // Immediate forms never wait on rs2
    operand_bypass #(.XLEN(XLEN)) u_operand_bypass (
        .i_rs1            (issue_rs1),
        .i_rs2            (issue_use_imm ? {REG_ADDR_W{1'b0}} : issue_rs2),
        .i_rf_rs1         (rf_rs1),
        .i_rf_rs2         (rf_rs2),
        .i_ex1_pending    (ex1_valid),
        .i_ex1_op         (ex1_op),
        .i_ex1_rd         (ex1_rd),
        .i_ex1_data       (ex1_data),
        .i_ex2_pending    (ex2_valid),
        .i_ex2_rd         (ex2_rd),
        .i_ex2_data_valid (ex2_data_valid),
        .i_ex2_data       (ex2_data),
        .o_rs1_value      (rs1_value),
        .o_rs2_value      (rs2_value),
        .o_stall          (stall)
    );

    alu #(.XLEN(XLEN)) u_alu (
        .i_op     (issue_op),
        .i_a      (rs1_value),
        .i_b      (op_b),
        .o_result (alu_result)
    );

    mul_unit #(.XLEN(XLEN)) u_mul_unit (
        .clk      (clk),
        .resetn   (resetn),
        .i_start  (ex1_go && ex1_unit == FU_MUL),
        .i_high   (ex1_op == OP_MULHU),
        .i_a      (ex1_data),
        .i_b      (ex1_data2),
        .o_done   (mul_done),
        .o_result (mul_result)
    );

    div_unit #(.XLEN(XLEN)) u_div_unit (
        .clk      (clk),
        .resetn   (resetn),
        .i_start  (ex1_go && ex1_unit == FU_DIV),
        .i_rem    (ex1_op == OP_REMU),
        .i_a      (ex1_data),
        .i_b      (ex1_data2),
        .o_done   (div_done),
        .o_result (div_result)
    );

endmodule

`default_nettype wire

// File: design/div_unit.sv
`default_nettype none

module div_unit #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            i_start,
    input  logic            i_rem,
    input  logic [XLEN-1:0] i_a,
    input  logic [XLEN-1:0] i_b,
    output logic            o_done,
    output logic [XLEN-1:0] o_result
);

    localparam int CNT_W = $clog2(XLEN + 1);

    logic             busy;
    logic [CNT_W-1:0] count;
    logic             rem_q;
    logic [XLEN-1:0]  divisor;
    logic [XLEN-1:0]  remainder;
    // Dividend shifts out the top while quotient bits enter at the bottom
    logic [XLEN-1:0]  quotient;
    logic [XLEN:0]    shifted;
    logic [XLEN:0]    diff;

    assign shifted = {remainder, quotient[XLEN-1]};
    assign diff    = shifted - {1'b0, divisor};

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy   <= 1'b0;
            count  <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                busy  <= 1'b1;
                count <= CNT_W'(XLEN);
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == CNT_W'(1)) begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    // A zero divisor never borrows, so quotient fills with ones
    // and the dividend ends up in the remainder
    always_ff @(posedge clk) begin
        if (i_start) begin
            divisor   <= i_b;
            remainder <= '0;
            quotient  <= i_a;
            rem_q     <= i_rem;
        end else if (busy) begin
            quotient  <= {quotient[XLEN-2:0], ~diff[XLEN]};
            // Restore on borrow
            remainder <= diff[XLEN] ? shifted[XLEN-1:0] : diff[XLEN-1:0];
        end
    end

    assign o_result = rem_q ? remainder : quotient;

endmodule

`default_nettype wire

// File: design/mul_unit.sv
`default_nettype none

module mul_unit #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            i_start,
    input  logic            i_high,
    input  logic [XLEN-1:0] i_a,
    input  logic [XLEN-1:0] i_b,
    output logic            o_done,
    output logic [XLEN-1:0] o_result
);

    localparam int CNT_W = $clog2(XLEN + 1);

    logic              busy;
    logic [CNT_W-1:0]  count;
    logic              high_q;
    logic [XLEN-1:0]   multiplicand;
    // Upper half accumulates, lower half shifts the multiplier out
    logic [2*XLEN-1:0] product;
    logic [XLEN:0]     partial;

    assign partial = {1'b0, product[2*XLEN-1:XLEN]} +
                     (product[0] ? {1'b0, multiplicand} : '0);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy   <= 1'b0;
            count  <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                busy  <= 1'b1;
                count <= CNT_W'(XLEN);
            end else if (busy) begin
                count <= count - 1'b1;
                // Last multiplier bit consumed
                if (count == CNT_W'(1)) begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            multiplicand <= i_a;
            product      <= {{XLEN{1'b0}}, i_b};
            high_q       <= i_high;
        end else if (busy) begin
            product <= {partial, product[XLEN-1:1]};
        end
    end

    assign o_result = high_q ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];

endmodule

`default_nettype wire

// File: design/alu.sv
`default_nettype none

module alu import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  exec_op_e        i_op,
    input  logic [XLEN-1:0] i_a,
    input  logic [XLEN-1:0] i_b,
    output logic [XLEN-1:0] o_result
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = i_b[SHAMT_W-1:0];
    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    always_comb begin
        case (i_op)
            OP_ADD: begin
                o_result = i_a + i_b;
            end
            OP_SUB: begin
                o_result = i_a - i_b;
            end
            OP_AND: begin
                o_result = i_a & i_b;
            end
            OP_OR: begin
                o_result = i_a | i_b;
            end
            OP_XOR: begin
                o_result = i_a ^ i_b;
            end
            OP_SLL: begin
                o_result = i_a << shamt;
            end
            OP_SRL: begin
                o_result = i_a >> shamt;
            end
            OP_SRA: begin
                o_result = $signed(i_a) >>> shamt;
            end
            OP_SLT: begin
                o_result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            OP_SLTU: begin
                o_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            // Multiply and divide are handled in EX2
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/operand_bypass.sv
`default_nettype none

module operand_bypass import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic [REG_ADDR_W-1:0] i_rs1,
    input  logic [REG_ADDR_W-1:0] i_rs2,
    input  logic [XLEN-1:0]       i_rf_rs1,
    input  logic [XLEN-1:0]       i_rf_rs2,
    input  logic                  i_ex1_pending,
    input  exec_op_e              i_ex1_op,
    input  logic [REG_ADDR_W-1:0] i_ex1_rd,
    input  logic [XLEN-1:0]       i_ex1_data,
    input  logic                  i_ex2_pending,
    input  logic [REG_ADDR_W-1:0] i_ex2_rd,
    input  logic                  i_ex2_data_valid,
    input  logic [XLEN-1:0]       i_ex2_data,
    output logic [XLEN-1:0]       o_rs1_value,
    output logic [XLEN-1:0]       o_rs2_value,
    output logic                  o_stall
);

    logic                  ex1_known;
    logic [REG_ADDR_W-1:0] src_sel [2];
    logic [XLEN-1:0]       src_rf  [2];
    logic [XLEN-1:0]       src_val [2];
    logic [1:0]            src_stall;

    // Only ALU results are ready while still in EX1
    assign ex1_known = unit_of(i_ex1_op) == FU_ALU;

    assign src_sel[0] = i_rs1;
    assign src_sel[1] = i_rs2;
    assign src_rf[0]  = i_rf_rs1;
    assign src_rf[1]  = i_rf_rs2;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            src_val[i]   = src_rf[i];
            src_stall[i] = 1'b0;
            if (src_sel[i] != '0) begin
                // Youngest producer wins
                if (i_ex1_pending && i_ex1_rd == src_sel[i]) begin
                    if (ex1_known) begin
                        src_val[i] = i_ex1_data;
                    end else begin
                        src_stall[i] = 1'b1;
                    end
                end else if (i_ex2_pending && i_ex2_rd == src_sel[i]) begin
                    if (i_ex2_data_valid) begin
                        src_val[i] = i_ex2_data;
                    end else begin
                        src_stall[i] = 1'b1;
                    end
                end
            end
        end
    end

    assign o_rs1_value = src_val[0];
    assign o_rs2_value = src_val[1];
    assign o_stall     = |src_stall;

endmodule

`default_nettype wire

// File: design/reg_file.sv
`default_nettype none

module reg_file import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [REG_ADDR_W-1:0] i_ra_sel,
    input  logic [REG_ADDR_W-1:0] i_rb_sel,
    input  logic                  i_ra_load,
    output logic [XLEN-1:0]       o_ra_data,
    output logic [XLEN-1:0]       o_rb_data,
    input  logic                  i_w_en,
    input  logic [REG_ADDR_W-1:0] i_w_sel,
    input  logic [XLEN-1:0]       i_w_data
);

    localparam int NREGS = 1 << REG_ADDR_W;

    logic [XLEN-1:0]       regs [NREGS];
    logic [REG_ADDR_W-1:0] ra_sel_q;
    logic [REG_ADDR_W-1:0] rb_sel_q;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ra_sel_q <= '0;
            rb_sel_q <= '0;
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_ra_load) begin
                ra_sel_q <= i_ra_sel;
                rb_sel_q <= i_rb_sel;
            end
            // x0 keeps its reset value
            if (i_w_en && i_w_sel != '0) begin
                regs[i_w_sel] <= i_w_data;
            end
        end
    end

    assign o_ra_data = regs[ra_sel_q];
    assign o_rb_data = regs[rb_sel_q];

endmodule

`default_nettype wire

// File: design/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // Width of an architectural register index
    localparam int REG_ADDR_W = 5;

    // Encoding order is shared with the stimulus file
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_MUL,
        OP_MULHU,
        OP_DIVU,
        OP_REMU
    } exec_op_e;

    typedef enum logic [1:0] {
        FU_ALU,
        FU_MUL,
        FU_DIV
    } func_unit_e;

    // Unit that produces the result of an operation
    function automatic func_unit_e unit_of(exec_op_e op);
        case (op)
            OP_MUL, OP_MULHU: begin
                return FU_MUL;
            end
            OP_DIVU, OP_REMU: begin
                return FU_DIV;
            end
            default: begin
                return FU_ALU;
            end
        endcase
    endfunction

endpackage

`default_nettype wire
